// ==== branchRs.f ====
+incdir+.
brRsPkg.sv
rsAllocIf.sv
brDispatchIn.sv
brRsQueue.sv
brIssueOut.sv
branchRs.sv
branchRsTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= branchRsTb
RTL_TOP ?= branchRs
FLIST ?= branchRs.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing -Wno-fatal
PASS_MSG ?= all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== branchRsTb.sv ====
`default_nettype none

`include "brRs_settings.svh"

module branchRsTb;

    localparam int TIMEOUT_CYCLES = 3000;

    logic clk;
    logic reset;
    logic flush;
    logic dispatchValid;
    brRsPkg::xlen_t instNum;
    brRsPkg::xlen_t pc;
    brRsPkg::xlen_t imm;
    brRsPkg::tag_t rd;
    brRsPkg::tag_t src1;
    brRsPkg::tag_t src2;
    logic src1Valid;
    logic src2Valid;
    logic branch;
    logic jump;
    logic [2:0] funct3;
    logic predTaken;
    logic btbHit;
    brRsPkg::wakeupVec_t wakeupValid;
    brRsPkg::tag_t wakeupTag [`BRRS_NUM_WAKEUP];
    logic issueCredit;
    logic dispatchCredit;
    logic issueValid;
    logic issueBranch;
    logic issueJump;
    logic issueHit;
    logic issueTaken;
    brRsPkg::tag_t issueRd;
    brRsPkg::xlen_t issueInstNum;
    logic [2:0] issueFunct3;
    brRsPkg::xlen_t issueImm;
    brRsPkg::xlen_t issuePc;
    brRsPkg::tag_t issueSrc1;
    brRsPkg::tag_t issueSrc2;

    brRsPkg::brEntry_t expQ [$]; // waiting entries in dispatch order
    int upCredits = 0;
    int issueCount = 0;
    int cycleCount = 0;
    int errorCount = 0;

    branchRs i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            stopOnError();
        end
    end

    task automatic stopOnError();
        $display("tests failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] want);
        if (got !== want) begin
            errorCount++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, want);
            stopOnError();
        end
    endtask

    task automatic failRun(input string what);
        errorCount++;
        $display("%s", what);
        stopOnError();
    endtask

    // compare one issue against the oldest modeled entry
    task automatic observeIssue();
        brRsPkg::brEntry_t want;
        if (issueValid !== 1'b1) begin
            checkValue("issueValid", issueValid, 0);
            checkValue("dispatchCredit", dispatchCredit, 0);
            checkValue("issueInstNum", issueInstNum, 0);
            checkValue("issuePc", issuePc, 0);
        end else if (expQ.size() == 0) begin
            failRun("an entry issued although none should be waiting");
        end else begin
            want = expQ.pop_front();
            checkValue("issueInstNum", issueInstNum, want.instNum);
            checkValue("issuePc", issuePc, want.pc);
            checkValue("issueImm", issueImm, want.imm);
            checkValue("issueRd", issueRd, want.rd);
            checkValue("issueSrc1", issueSrc1, want.src1);
            checkValue("issueSrc2", issueSrc2, want.src2);
            checkValue("issueBranch", issueBranch, want.branch);
            checkValue("issueJump", issueJump, want.jump);
            checkValue("issueFunct3", issueFunct3, want.funct3);
            checkValue("issueTaken", issueTaken, want.predTaken);
            checkValue("issueHit", issueHit, want.btbHit);
            checkValue("dispatchCredit", dispatchCredit, 1);
            issueCount++;
            upCredits++;
        end
    endtask

    // advance one clock and drop the pulse inputs
    task automatic tick();
        @(posedge clk);
        #1;
        observeIssue();
        dispatchValid = 1'b0;
        issueCredit = 1'b0;
        flush = 1'b0;
        wakeupValid = '0;
    endtask

    task automatic idleCycles(input int n);
        repeat (n) tick();
    endtask

    task automatic waitIssues(input int target);
        while (issueCount < target) begin
            tick();
        end
    endtask

    function automatic brRsPkg::brEntry_t randomEntry();
        brRsPkg::brEntry_t e;
        e.instNum = $urandom;
        e.pc = $urandom;
        e.imm = $urandom;
        e.rd = brRsPkg::tag_t'($urandom);
        e.src1 = brRsPkg::tag_t'($urandom);
        e.src2 = brRsPkg::tag_t'($urandom);
        e.branch = 1'($urandom);
        e.jump = ~e.branch;
        e.funct3 = 3'($urandom);
        e.predTaken = 1'($urandom);
        e.btbHit = 1'($urandom);
        return e;
    endfunction

    task automatic setDispatch(input brRsPkg::brEntry_t e, input logic s1v, input logic s2v);
        if (upCredits <= 0) begin
            failRun("upstream tried to dispatch without a credit");
        end else begin
            dispatchValid = 1'b1;
            instNum = e.instNum;
            pc = e.pc;
            imm = e.imm;
            rd = e.rd;
            src1 = e.src1;
            src2 = e.src2;
            branch = e.branch;
            jump = e.jump;
            funct3 = e.funct3;
            predTaken = e.predTaken;
            btbHit = e.btbHit;
            src1Valid = s1v;
            src2Valid = s2v;
            expQ.push_back(e);
            upCredits--;
        end
    endtask

    task automatic resetQuiet();
        idleCycles(5);
        checkValue("issueRd", issueRd, 0);
        checkValue("issueImm", issueImm, 0);
        checkValue("issueSrc1", issueSrc1, 0);
        checkValue("issueSrc2", issueSrc2, 0);
    endtask

    task automatic readyInOrder();
        int base;
        for (int i = 0; i < 3; i++) begin
            base = issueCount;
            setDispatch(randomEntry(), 1'b1, 1'b1);
            issueCredit = 1'b1;
            tick();
            checkValue("issue count", issueCount, base);
            tick();
            checkValue("issue count", issueCount, base + 1);
        end
    endtask

    task automatic headBlocks();
        brRsPkg::brEntry_t a;
        int base;
        base = issueCount;
        a = randomEntry();
        setDispatch(a, 1'b1, 1'b0);
        issueCredit = 1'b1;
        tick();
        setDispatch(randomEntry(), 1'b1, 1'b1);
        issueCredit = 1'b1;
        tick();
        idleCycles(6);
        checkValue("issue count", issueCount, base); // younger one must wait too
        wakeupValid[3] = 1'b1;
        wakeupTag[3] = a.src2;
        tick();
        waitIssues(base + 2);
    endtask

    task automatic dispatchBypass();
        brRsPkg::brEntry_t e;
        int base;
        base = issueCount;
        e = randomEntry();
        setDispatch(e, 1'b0, 1'b1);
        wakeupValid[1] = 1'b1;
        wakeupTag[1] = e.src1;
        issueCredit = 1'b1;
        tick();
        tick();
        checkValue("issue count", issueCount, base + 1);
        // same tag on a bus that is not valid
        e = randomEntry();
        setDispatch(e, 1'b0, 1'b1);
        wakeupTag[4] = e.src1;
        issueCredit = 1'b1;
        tick();
        idleCycles(6);
        checkValue("issue count", issueCount, base + 1);
        wakeupValid[0] = 1'b1;
        wakeupTag[0] = e.src1;
        tick();
        waitIssues(base + 2);
    endtask

    task automatic creditBackPressure();
        int base;
        base = issueCount;
        checkValue("upstream credits", upCredits, `BRRS_DEPTH);
        for (int i = 0; i < `BRRS_DEPTH; i++) begin
            setDispatch(randomEntry(), 1'b1, 1'b1);
            tick();
        end
        idleCycles(4);
        checkValue("issue count", issueCount, base);
        checkValue("upstream credits", upCredits, 0);
        for (int i = 0; i < `BRRS_DEPTH; i++) begin
            issueCredit = 1'b1;
            tick();
            tick();
            checkValue("issue count", issueCount, base + i + 1);
        end
        idleCycles(3);
        checkValue("issue count", issueCount, base + `BRRS_DEPTH);
        checkValue("upstream credits", upCredits, `BRRS_DEPTH);
    endtask

    task automatic flushEmpties();
        int base;
        base = issueCount;
        setDispatch(randomEntry(), 1'b1, 1'b1);
        tick();
        setDispatch(randomEntry(), 1'b1, 1'b1);
        tick();
        flush = 1'b1;
        expQ.delete();
        upCredits = `BRRS_DEPTH; // credits restart full after a flush
        tick();
        issueCredit = 1'b1;
        tick();
        idleCycles(6); // model is empty so any issue fails
        setDispatch(randomEntry(), 1'b1, 1'b1);
        tick();
        tick();
        checkValue("issue count", issueCount, base + 1);
        checkValue("upstream credits", upCredits, `BRRS_DEPTH);
    endtask

    initial begin
        void'($urandom(27));
        reset = 1'b1;
        flush = 1'b0;
        dispatchValid = 1'b0;
        instNum = '0;
        pc = '0;
        imm = '0;
        rd = '0;
        src1 = '0;
        src2 = '0;
        src1Valid = 1'b0;
        src2Valid = 1'b0;
        branch = 1'b0;
        jump = 1'b0;
        funct3 = '0;
        predTaken = 1'b0;
        btbHit = 1'b0;
        wakeupValid = '0;
        issueCredit = 1'b0;
        for (int b = 0; b < `BRRS_NUM_WAKEUP; b++) begin
            wakeupTag[b] = '0;
        end
        idleCycles(5);
        reset = 1'b0;
        upCredits = `BRRS_DEPTH;

        resetQuiet();
        readyInOrder();
        headBlocks();
        dispatchBypass();
        creditBackPressure();
        flushEmpties();

        if (errorCount == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            stopOnError();
        end
    end

endmodule

`default_nettype wire

// ==== branchRs.sv ====
`default_nettype none

`include "brRs_settings.svh"

module branchRs (
    input  logic clk,
    input  logic reset,
    input  logic flush,
    input  logic dispatchValid,
    input  brRsPkg::xlen_t instNum,
    input  brRsPkg::xlen_t pc,
    input  brRsPkg::xlen_t imm,
    input  brRsPkg::tag_t rd,
    input  brRsPkg::tag_t src1,
    input  brRsPkg::tag_t src2,
    input  logic src1Valid,
    input  logic src2Valid,
    input  logic branch,
    input  logic jump,
    input  logic [2:0] funct3,
    input  logic predTaken,
    input  logic btbHit,
    input  brRsPkg::wakeupVec_t wakeupValid,
    input  brRsPkg::tag_t wakeupTag [`BRRS_NUM_WAKEUP],
    input  logic issueCredit,
    output logic dispatchCredit,
    output logic issueValid,
    output logic issueBranch,
    output logic issueJump,
    output logic issueHit,
    output logic issueTaken,
    output brRsPkg::tag_t issueRd,
    output brRsPkg::xlen_t issueInstNum,
    output logic [2:0] issueFunct3,
    output brRsPkg::xlen_t issueImm,
    output brRsPkg::xlen_t issuePc,
    output brRsPkg::tag_t issueSrc1,
    output brRsPkg::tag_t issueSrc2
);

    brRsPkg::brEntry_t entryIn;
    brRsPkg::brEntry_t headEntry;
    logic headReady;
    logic pop;

    rsAllocIf allocBus ();

    // pack the dispatch fields into one entry
    assign entryIn = '{
        instNum: instNum,
        pc: pc,
        rd: rd,
        src1: src1,
        src2: src2,
        branch: branch,
        jump: jump,
        funct3: funct3,
        imm: imm,
        predTaken: predTaken,
        btbHit: btbHit
    };

    brDispatchIn u_dispatchIn (
        .dispatchValid(dispatchValid),
        .entryIn(entryIn),
        .src1Valid(src1Valid),
        .src2Valid(src2Valid),
        .wakeupValid(wakeupValid),
        .wakeupTag(wakeupTag),
        .alloc(allocBus.source)
    );

    brRsQueue u_queue (
        .clk(clk),
        .reset(reset),
        .flush(flush),
        .alloc(allocBus.sink),
        .wakeupValid(wakeupValid),
        .wakeupTag(wakeupTag),
        .pop(pop),
        .headReady(headReady),
        .headEntry(headEntry)
    );

    brIssueOut u_issueOut (
        .clk(clk),
        .reset(reset),
        .flush(flush),
        .headReady(headReady),
        .headEntry(headEntry),
        .issueCredit(issueCredit),
        .pop(pop),
        .dispatchCredit(dispatchCredit),
        .issueValid(issueValid),
        .issueBranch(issueBranch),
        .issueJump(issueJump),
        .issueHit(issueHit),
        .issueTaken(issueTaken),
        .issueRd(issueRd),
        .issueInstNum(issueInstNum),
        .issueFunct3(issueFunct3),
        .issueImm(issueImm),
        .issuePc(issuePc),
        .issueSrc1(issueSrc1),
        .issueSrc2(issueSrc2)
    );

endmodule

`default_nettype wire

// ==== brIssueOut.sv ====
`default_nettype none

module brIssueOut (
    input  logic clk,
    input  logic reset,
    input  logic flush,
    input  logic headReady,
    input  brRsPkg::brEntry_t headEntry,
    input  logic issueCredit,
    output logic pop,
    output logic dispatchCredit,
    output logic issueValid,
    output logic issueBranch,
    output logic issueJump,
    output logic issueHit,
    output logic issueTaken,
    output brRsPkg::tag_t issueRd,
    output brRsPkg::xlen_t issueInstNum,
    output logic [2:0] issueFunct3,
    output brRsPkg::xlen_t issueImm,
    output brRsPkg::xlen_t issuePc,
    output brRsPkg::tag_t issueSrc1,
    output brRsPkg::tag_t issueSrc2
);

    brRsPkg::credit_t creditCount;
    brRsPkg::brEntry_t issueReg;

    // no pop while flushing, the head is about to vanish
    assign pop = headReady && (creditCount != '0) && !flush;

    // issue slots granted by the branch unit, kept across flush
    always_ff @(posedge clk) begin
        if (reset) begin
            creditCount <= '0;
        end else begin
            case ({issueCredit, pop})
                2'b10: creditCount <= creditCount + 1'b1;
                2'b01: creditCount <= creditCount - 1'b1;
                default: creditCount <= creditCount; // both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            issueValid <= 1'b0;
            dispatchCredit <= 1'b0;
            issueReg <= '0;
        end else begin
            issueValid <= pop;
            dispatchCredit <= pop; // one slot freed per issue
            issueReg <= pop ? headEntry : '0;
        end
    end

    assign issueBranch = issueReg.branch;
    assign issueJump = issueReg.jump;
    assign issueHit = issueReg.btbHit;
    assign issueTaken = issueReg.predTaken;
    assign issueRd = issueReg.rd;
    assign issueInstNum = issueReg.instNum;
    assign issueFunct3 = issueReg.funct3;
    assign issueImm = issueReg.imm;
    assign issuePc = issueReg.pc;
    assign issueSrc1 = issueReg.src1;
    assign issueSrc2 = issueReg.src2;

endmodule

`default_nettype wire

// ==== brRsQueue.sv ====
`default_nettype none

`include "brRs_settings.svh"

module brRsQueue (
    input  logic clk,
    input  logic reset,
    input  logic flush,
    rsAllocIf.sink alloc,
    input  brRsPkg::wakeupVec_t wakeupValid,
    input  brRsPkg::tag_t wakeupTag [`BRRS_NUM_WAKEUP],
    input  logic pop,
    output logic headReady,
    output brRsPkg::brEntry_t headEntry
);

    brRsPkg::brEntry_t entries [`BRRS_DEPTH];

    logic [`BRRS_DEPTH-1:0] occupied;
    logic [`BRRS_DEPTH-1:0] rdy1;
    logic [`BRRS_DEPTH-1:0] rdy2;
    logic [`BRRS_DEPTH-1:0] hit1;
    logic [`BRRS_DEPTH-1:0] hit2;

    brRsPkg::ptr_t head;
    brRsPkg::ptr_t tail;
    brRsPkg::ptr_t headNext;
    brRsPkg::ptr_t tailNext;

    // ring wrap, also correct for a depth that is not a power of two
    assign headNext = (head == brRsPkg::ptr_t'(`BRRS_DEPTH - 1)) ? '0 : head + 1'b1;
    assign tailNext = (tail == brRsPkg::ptr_t'(`BRRS_DEPTH - 1)) ? '0 : tail + 1'b1;

    // broadcast wakeup against every stored entry
    always_comb begin
        hit1 = '0;
        hit2 = '0;
        for (int i = 0; i < `BRRS_DEPTH; i++) begin
            for (int b = 0; b < `BRRS_NUM_WAKEUP; b++) begin
                if (wakeupValid[b] && entries[i].src1 == wakeupTag[b]) begin
                    hit1[i] = 1'b1;
                end
                if (wakeupValid[b] && entries[i].src2 == wakeupTag[b]) begin
                    hit2[i] = 1'b1;
                end
            end
        end
    end

    // payload store
    always_ff @(posedge clk) begin
        if (alloc.allocValid) begin
            entries[tail] <= alloc.allocEntry;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head <= '0;
            tail <= '0;
            occupied <= '0;
            rdy1 <= '0;
            rdy2 <= '0;
        end else begin
            for (int i = 0; i < `BRRS_DEPTH; i++) begin
                if (occupied[i]) begin
                    rdy1[i] <= rdy1[i] | hit1[i];
                    rdy2[i] <= rdy2[i] | hit2[i];
                end
            end

            if (pop) begin
                occupied[head] <= 1'b0;
                head <= headNext;
            end

            // the tail slot is free here, dispatch credits see to that
            if (alloc.allocValid) begin
                occupied[tail] <= 1'b1;
                rdy1[tail] <= alloc.src1Ready;
                rdy2[tail] <= alloc.src2Ready;
                tail <= tailNext;
            end
        end
    end

    // only the oldest entry may issue
    assign headReady = occupied[head] && rdy1[head] && rdy2[head];
    assign headEntry = entries[head];

endmodule

`default_nettype wire

// ==== brDispatchIn.sv ====
`default_nettype none

`include "brRs_settings.svh"

module brDispatchIn (
    input  logic dispatchValid,
    input  brRsPkg::brEntry_t entryIn,
    input  logic src1Valid,
    input  logic src2Valid,
    input  brRsPkg::wakeupVec_t wakeupValid,
    input  brRsPkg::tag_t wakeupTag [`BRRS_NUM_WAKEUP],
    rsAllocIf.source alloc
);

    brRsPkg::wakeupVec_t match1;
    brRsPkg::wakeupVec_t match2;
    logic bypass1;
    logic bypass2;

    // compare both source tags against every result bus
    always_comb begin
        for (int b = 0; b < `BRRS_NUM_WAKEUP; b++) begin
            match1[b] = wakeupValid[b] && (entryIn.src1 == wakeupTag[b]);
            match2[b] = wakeupValid[b] && (entryIn.src2 == wakeupTag[b]);
        end
    end

    // result lands in the same cycle as dispatch
    assign bypass1 = |match1;
    assign bypass2 = |match2;

    assign alloc.allocValid = dispatchValid;
    assign alloc.allocEntry = entryIn;
    assign alloc.src1Ready = src1Valid || bypass1;
    assign alloc.src2Ready = src2Valid || bypass2;

endmodule

`default_nettype wire

// ==== rsAllocIf.sv ====
`default_nettype none

// one allocation per cycle into the tail of the queue
interface rsAllocIf;

    logic allocValid;
    brRsPkg::brEntry_t allocEntry;
    logic src1Ready;
    logic src2Ready;

    modport source (
        output allocValid,
        output allocEntry,
        output src1Ready,
        output src2Ready
    );

    modport sink (
        input allocValid,
        input allocEntry,
        input src1Ready,
        input src2Ready
    );

endinterface

`default_nettype wire

// ==== brRsPkg.sv ====
`default_nettype none

`include "brRs_settings.svh"

package brRsPkg;

    localparam int PTR_W = $clog2(`BRRS_DEPTH);

    typedef logic [`BRRS_TAG_W-1:0] tag_t;
    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [`BRRS_XLEN-1:0] xlen_t;
    typedef logic [`BRRS_CREDIT_W-1:0] credit_t;

    // one bit per result bus
    typedef logic [`BRRS_NUM_WAKEUP-1:0] wakeupVec_t;

    // one queued branch or jump
    typedef struct packed {
        xlen_t instNum;
        xlen_t pc;
        tag_t rd;
        tag_t src1;
        tag_t src2;
        logic branch;
        logic jump;
        logic [2:0] funct3;
        xlen_t imm;
        logic predTaken; // from the predictor at fetch
        logic btbHit;
    } brEntry_t;

endpackage

`default_nettype wire

// ==== brRs_settings.svh ====
`ifndef BRRS_SETTINGS_SVH
`define BRRS_SETTINGS_SVH

// number of station entries
`define BRRS_DEPTH 64

// physical register tag width
`define BRRS_TAG_W 8

// pc, immediate and instruction number width
`define BRRS_XLEN 32

// alu, mul, div, load, branch, sixth pipe
`define BRRS_NUM_WAKEUP 6

// credit counters, wide enough to hold the full depth
`define BRRS_CREDIT_W 7

`endif
